// ==== verilog/conv_pkg.sv ====
// ****************************
// widths, register map, FSM states and bus structs shared by
// every block of the I/Q converter front-end
// ****************************

`default_nettype none

package conv_pkg;

  // ****************************
  // widths and constants
  // ****************************

  localparam int SAMPLE_W = 12;
  localparam int WORD_W   = 16;
  localparam int APB_AW   = 8;
  localparam int APB_DW   = 32;

  // major.minor.patch in the upper three bytes
  localparam logic [APB_DW-1:0] CORE_VERSION = 32'h0001_0200;

  // register byte addresses
  typedef enum logic [APB_AW-1:0] {
    REG_VERSION  = 8'h00,
    REG_CTRL     = 8'h04,
    REG_RX_COUNT = 8'h08,
    REG_STATUS   = 8'h0C
  } reg_addr_e;

  // transmit serializer phases
  typedef enum logic [1:0] {
    TX_IDLE,
    TX_I,
    TX_Q
  } tx_phase_e;

  // ****************************
  // bus structs
  // ****************************

  typedef struct packed {
    logic [APB_AW-1:0] paddr;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [APB_DW-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [APB_DW-1:0] prdata;
    logic              pready;
    logic              pslverr;
  } apb_rsp_t;

  typedef struct packed {
    logic [SAMPLE_W-1:0] i;
    logic [SAMPLE_W-1:0] q;
  } raw_pair_t;

  typedef struct packed {
    logic [WORD_W-1:0] i;
    logic [WORD_W-1:0] q;
  } iq_pair_t;

  // field order puts rx_en on bit 0, same as REG_CTRL
  typedef struct packed {
    logic loopback;
    logic offset_bin;
    logic tx_en;
    logic rx_en;
  } conv_ctrl_t;

endpackage

`default_nettype wire

// ==== verilog/conv_apb_regs.sv ====
// ****************************
// APB register bank: control bits, delivered pair count and
// sticky overflow/underflow flags, zero wait states
// ****************************

`timescale 1ns/10ps
`default_nettype none

module conv_apb_regs (
  input  wire logic                 up_clk_i,
  input  wire logic                 reset_i,
  input  wire conv_pkg::apb_req_t   apb_req_i,
  output conv_pkg::apb_rsp_t        apb_rsp_o,
  output conv_pkg::conv_ctrl_t      ctrl_o,
  input  wire logic                 rx_pair_pulse_i,
  input  wire logic                 adc_dovf_i,
  input  wire logic                 dac_dunf_i
);

  logic                          access;
  logic                          wr_en;
  logic                          addr_hit;
  logic                          wr_ctrl;
  logic                          wr_count;
  logic                          wr_status;
  logic [conv_pkg::APB_DW-1:0]   rd_data;
  conv_pkg::conv_ctrl_t          ctrl_q;
  logic [conv_pkg::APB_DW-1:0]   rx_count_q;
  logic [1:0]                    status_q;

  // access phase, always completes in one cycle
  assign access = apb_req_i.psel & apb_req_i.penable;
  assign wr_en  = access & apb_req_i.pwrite;

  assign wr_ctrl   = wr_en & (apb_req_i.paddr == conv_pkg::REG_CTRL);
  assign wr_count  = wr_en & (apb_req_i.paddr == conv_pkg::REG_RX_COUNT);
  assign wr_status = wr_en & (apb_req_i.paddr == conv_pkg::REG_STATUS);

  // ****************************
  // read mux
  // ****************************

  always_comb begin
    addr_hit = 1'b1;
    rd_data  = '0;
    case (apb_req_i.paddr)
      conv_pkg::REG_VERSION:  rd_data = conv_pkg::CORE_VERSION;
      conv_pkg::REG_CTRL:     rd_data[$bits(ctrl_q)-1:0] = ctrl_q;
      conv_pkg::REG_RX_COUNT: rd_data = rx_count_q;
      conv_pkg::REG_STATUS:   rd_data[1:0] = status_q;
      default: begin
        addr_hit = 1'b0;
      end
    endcase
  end

  always_comb begin
    apb_rsp_o.prdata  = rd_data;
    apb_rsp_o.pready  = 1'b1;
    apb_rsp_o.pslverr = access & ~addr_hit;
  end

  // ****************************
  // register state
  // ****************************

  always_ff @(posedge up_clk_i) begin
    if (reset_i) begin
      ctrl_q     <= '0;
      rx_count_q <= '0;
      status_q   <= '0;
    end else begin
      if (wr_ctrl) begin
        ctrl_q <= apb_req_i.pwdata[$bits(ctrl_q)-1:0];
      end
      // a pair landing on the clear cycle still counts
      if (wr_count) begin
        rx_count_q <= {{(conv_pkg::APB_DW-1){1'b0}}, rx_pair_pulse_i};
      end else if (rx_pair_pulse_i) begin
        rx_count_q <= rx_count_q + 1'b1;
      end
      // write 1 to clear, new event wins
      status_q[0] <= adc_dovf_i | (status_q[0] & ~(wr_status & apb_req_i.pwdata[0]));
      status_q[1] <= dac_dunf_i | (status_q[1] & ~(wr_status & apb_req_i.pwdata[1]));
    end
  end

  assign ctrl_o = ctrl_q;

endmodule

`default_nettype wire

// ==== verilog/conv_rx_deinterleave.sv ====
// ****************************
// pairs the interleaved receive bus into I/Q samples,
// one valid pulse the cycle after each Q sample
// ****************************

`timescale 1ns/10ps
`default_nettype none

module conv_rx_deinterleave (
  input  wire logic                           up_clk_i,
  input  wire logic                           reset_i,
  input  wire logic                           trx_iq_i,
  input  wire logic [conv_pkg::SAMPLE_W-1:0]  trx_data_i,
  output conv_pkg::raw_pair_t                 raw_pair_o,
  output logic                                raw_valid_o
);

  logic [conv_pkg::SAMPLE_W-1:0] i_hold_q;
  logic                          i_pending_q;
  conv_pkg::raw_pair_t           pair_q;
  logic                          valid_q;

  // control: waiting for Q, and the output strobe
  always_ff @(posedge up_clk_i) begin
    if (reset_i) begin
      i_pending_q <= 1'b0;
      valid_q     <= 1'b0;
    end else begin
      valid_q <= ~trx_iq_i & i_pending_q;
      if (trx_iq_i) begin
        i_pending_q <= 1'b1;
      end else begin
        // Q consumed, or an orphan Q dropped
        i_pending_q <= 1'b0;
      end
    end
  end

  // payload
  always_ff @(posedge up_clk_i) begin
    if (trx_iq_i) begin
      i_hold_q <= trx_data_i;
    end
    if (!trx_iq_i && i_pending_q) begin
      pair_q.i <= i_hold_q;
      pair_q.q <= trx_data_i;
    end
  end

  assign raw_pair_o  = pair_q;
  assign raw_valid_o = valid_q;

endmodule

`default_nettype wire

// ==== verilog/conv_rx_format.sv ====
// ****************************
// 12-bit device samples to 16-bit sign-extended words,
// receive gating and the loopback copy
// ****************************

`timescale 1ns/10ps
`default_nettype none

module conv_rx_format (
  input  wire logic                  up_clk_i,
  input  wire logic                  reset_i,
  input  wire conv_pkg::conv_ctrl_t  ctrl_i,
  input  wire conv_pkg::raw_pair_t   raw_pair_i,
  input  wire logic                  raw_valid_i,
  output conv_pkg::iq_pair_t         adc_pair_o,
  output logic                       adc_valid_o,
  output conv_pkg::iq_pair_t         loop_pair_o
);

  conv_pkg::iq_pair_t conv_pair;
  conv_pkg::iq_pair_t adc_pair_q;
  conv_pkg::iq_pair_t loop_pair_q;
  logic               adc_valid_q;

  // flip the MSB for offset binary, then sign extend
  function automatic logic [conv_pkg::WORD_W-1:0] to_word(
    input logic [conv_pkg::SAMPLE_W-1:0] sample,
    input logic                          offset_bin
  );
    logic [conv_pkg::SAMPLE_W-1:0] twos;
    twos = sample;
    twos[conv_pkg::SAMPLE_W-1] = sample[conv_pkg::SAMPLE_W-1] ^ offset_bin;
    return {{(conv_pkg::WORD_W-conv_pkg::SAMPLE_W){twos[conv_pkg::SAMPLE_W-1]}}, twos};
  endfunction

  assign conv_pair.i = to_word(raw_pair_i.i, ctrl_i.offset_bin);
  assign conv_pair.q = to_word(raw_pair_i.q, ctrl_i.offset_bin);

  always_ff @(posedge up_clk_i) begin
    if (reset_i) begin
      adc_valid_q <= 1'b0;
      loop_pair_q <= '0;
    end else begin
      adc_valid_q <= raw_valid_i & ctrl_i.rx_en;
      // loopback sees every pair, enabled or not
      if (raw_valid_i) begin
        loop_pair_q <= conv_pair;
      end
    end
  end

  always_ff @(posedge up_clk_i) begin
    if (raw_valid_i && ctrl_i.rx_en) begin
      adc_pair_q <= conv_pair;
    end
  end

  assign adc_pair_o  = adc_pair_q;
  assign adc_valid_o = adc_valid_q;
  assign loop_pair_o = loop_pair_q;

endmodule

`default_nettype wire

// ==== verilog/conv_tx_interleave.sv ====
// ****************************
// transmit serializer: fetches a DMA or loopback pair in TX_Q
// and drives I then Q onto the interleaved bus
// ****************************

`timescale 1ns/10ps
`default_nettype none

module conv_tx_interleave (
  input  wire logic                           up_clk_i,
  input  wire logic                           reset_i,
  input  wire conv_pkg::conv_ctrl_t           ctrl_i,
  input  wire conv_pkg::iq_pair_t             dac_pair_i,
  input  wire conv_pkg::iq_pair_t             loop_pair_i,
  output logic                                dac_valid_o,
  output logic                                tx_iq_o,
  output logic [conv_pkg::SAMPLE_W-1:0]       tx_data_o
);

  conv_pkg::tx_phase_e  state_q;
  conv_pkg::tx_phase_e  state_d;
  conv_pkg::iq_pair_t   src_pair;
  conv_pkg::raw_pair_t  hold_q;
  logic                 fetch;

  // upper bits of the word, MSB flipped for offset binary
  function automatic logic [conv_pkg::SAMPLE_W-1:0] to_sample(
    input logic [conv_pkg::WORD_W-1:0] word,
    input logic                        offset_bin
  );
    logic [conv_pkg::SAMPLE_W-1:0] upper;
    upper = word[conv_pkg::WORD_W-1 -: conv_pkg::SAMPLE_W];
    upper[conv_pkg::SAMPLE_W-1] = upper[conv_pkg::SAMPLE_W-1] ^ offset_bin;
    return upper;
  endfunction

  // ****************************
  // phase FSM
  // ****************************

  always_comb begin
    state_d = state_q;
    if (!ctrl_i.tx_en) begin
      state_d = conv_pkg::TX_IDLE;
    end else begin
      case (state_q)
        conv_pkg::TX_IDLE: state_d = conv_pkg::TX_Q;
        conv_pkg::TX_I:    state_d = conv_pkg::TX_Q;
        conv_pkg::TX_Q:    state_d = conv_pkg::TX_I;
        default:           state_d = conv_pkg::TX_IDLE;
      endcase
    end
  end

  assign fetch       = (state_q == conv_pkg::TX_Q);
  assign dac_valid_o = fetch & ~ctrl_i.loopback;
  assign src_pair    = ctrl_i.loopback ? loop_pair_i : dac_pair_i;

  always_ff @(posedge up_clk_i) begin
    if (reset_i) begin
      state_q <= conv_pkg::TX_IDLE;
      hold_q  <= '0;
    end else begin
      state_q <= state_d;
      if (fetch) begin
        hold_q.i <= to_sample(src_pair.i, ctrl_i.offset_bin);
        hold_q.q <= to_sample(src_pair.q, ctrl_i.offset_bin);
      end
    end
  end

  // bus drive, Q phase overlaps the next fetch
  always_comb begin
    tx_iq_o   = 1'b0;
    tx_data_o = '0;
    case (state_q)
      conv_pkg::TX_I: begin
        tx_iq_o   = 1'b1;
        tx_data_o = hold_q.i;
      end
      conv_pkg::TX_Q: begin
        tx_data_o = hold_q.q;
      end
      default: begin
        tx_data_o = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/conv_core.sv ====
// ****************************
// converter front-end top: APB registers, receive
// deinterleave and format, transmit serializer
// ****************************

`timescale 1ns/10ps
`default_nettype none

module conv_core (
  input  wire logic                           up_clk_i,
  input  wire logic                           reset_i,

  // APB
  input  wire conv_pkg::apb_req_t             apb_req_i,
  output conv_pkg::apb_rsp_t                  apb_rsp_o,

  // device receive
  input  wire logic                           trx_iq_i,
  input  wire logic [conv_pkg::SAMPLE_W-1:0]  trx_data_i,

  // device transmit
  output logic                                tx_iq_o,
  output logic [conv_pkg::SAMPLE_W-1:0]       tx_data_o,

  // receive DMA
  output logic                                adc_enable_i_o,
  output logic                                adc_valid_i_o,
  output logic [conv_pkg::WORD_W-1:0]         adc_data_i_o,
  output logic                                adc_enable_q_o,
  output logic                                adc_valid_q_o,
  output logic [conv_pkg::WORD_W-1:0]         adc_data_q_o,
  input  wire logic                           adc_dovf_i,

  // transmit DMA
  output logic                                dac_enable_i_o,
  output logic                                dac_valid_i_o,
  input  wire logic [conv_pkg::WORD_W-1:0]    dac_data_i_i,
  output logic                                dac_enable_q_o,
  output logic                                dac_valid_q_o,
  input  wire logic [conv_pkg::WORD_W-1:0]    dac_data_q_i,
  input  wire logic                           dac_dunf_i
);

  conv_pkg::conv_ctrl_t ctrl;
  conv_pkg::raw_pair_t  raw_pair;
  logic                 raw_valid;
  conv_pkg::iq_pair_t   adc_pair;
  logic                 adc_valid;
  conv_pkg::iq_pair_t   loop_pair;
  conv_pkg::iq_pair_t   dac_pair;
  logic                 dac_valid;

  conv_apb_regs i_regs (
    .up_clk_i        (up_clk_i),
    .reset_i         (reset_i),
    .apb_req_i       (apb_req_i),
    .apb_rsp_o       (apb_rsp_o),
    .ctrl_o          (ctrl),
    .rx_pair_pulse_i (adc_valid),
    .adc_dovf_i      (adc_dovf_i),
    .dac_dunf_i      (dac_dunf_i)
  );

  // receive
  conv_rx_deinterleave i_rx_deint (
    .up_clk_i    (up_clk_i),
    .reset_i     (reset_i),
    .trx_iq_i    (trx_iq_i),
    .trx_data_i  (trx_data_i),
    .raw_pair_o  (raw_pair),
    .raw_valid_o (raw_valid)
  );

  conv_rx_format i_rx_fmt (
    .up_clk_i    (up_clk_i),
    .reset_i     (reset_i),
    .ctrl_i      (ctrl),
    .raw_pair_i  (raw_pair),
    .raw_valid_i (raw_valid),
    .adc_pair_o  (adc_pair),
    .adc_valid_o (adc_valid),
    .loop_pair_o (loop_pair)
  );

  // transmit
  conv_tx_interleave i_tx (
    .up_clk_i    (up_clk_i),
    .reset_i     (reset_i),
    .ctrl_i      (ctrl),
    .dac_pair_i  (dac_pair),
    .loop_pair_i (loop_pair),
    .dac_valid_o (dac_valid),
    .tx_iq_o     (tx_iq_o),
    .tx_data_o   (tx_data_o)
  );

  // per-channel DMA ports
  assign adc_enable_i_o = ctrl.rx_en;
  assign adc_enable_q_o = ctrl.rx_en;
  assign adc_valid_i_o  = adc_valid;
  assign adc_valid_q_o  = adc_valid;
  assign adc_data_i_o   = adc_pair.i;
  assign adc_data_q_o   = adc_pair.q;

  assign dac_enable_i_o = ctrl.tx_en;
  assign dac_enable_q_o = ctrl.tx_en;
  assign dac_valid_i_o  = dac_valid;
  assign dac_valid_q_o  = dac_valid;
  assign dac_pair.i     = dac_data_i_i;
  assign dac_pair.q     = dac_data_q_i;

endmodule

`default_nettype wire

// ==== verification/conv_tb_clkgen.sv ====
// ****************************
// free-running testbench clock, 20 ns period
// ****************************

`timescale 1ns/10ps
`default_nettype none

module conv_tb_clkgen (
  output logic clk_o
);

  localparam time HALF_PERIOD = 10ns;

  initial begin
    clk_o = 1'b0;
  end

  always #(HALF_PERIOD) clk_o = ~clk_o;

endmodule

`default_nettype wire

// ==== verification/conv_tb.sv ====
// ****************************
// drives random I/Q traffic and APB accesses into the converter
// front-end and checks every output against a cycle model
// ****************************

`timescale 1ns/10ps
`default_nettype none

module conv_tb;

  localparam int RX_PAIRS     = 40;
  localparam int TX_PAIRS     = 24;
  localparam int LOOP_FETCHES = 6;
  // 4 cycles per receive pair over three streams and 2 per transmit pair plus margin
  localparam int WATCHDOG_CYCLES =
    4 * (3 * RX_PAIRS) + 2 * (2 * TX_PAIRS) + 2 * LOOP_FETCHES + 400;

  logic                 clk;
  logic                 reset_i;
  conv_pkg::apb_req_t   apb_req;
  conv_pkg::apb_rsp_t   apb_rsp;
  logic                 trx_iq;
  logic [11:0]          trx_data;
  logic                 tx_iq;
  logic [11:0]          tx_data;
  logic                 adc_enable_i, adc_valid_i, adc_enable_q, adc_valid_q;
  logic [15:0]          adc_data_i, adc_data_q;
  logic                 adc_dovf;
  logic                 dac_enable_i, dac_valid_i, dac_enable_q, dac_valid_q;
  logic [15:0]          dac_data_i, dac_data_q;
  logic                 dac_dunf;

  // model state
  logic [31:0]          lcg_state;
  conv_pkg::conv_ctrl_t model_ctrl;
  int                   cyc;
  int                   errors;
  bit                   checking;
  bit                   pend;
  logic [11:0]          held_i;
  int                   exp_cyc[$];
  logic [15:0]          exp_i[$];
  logic [15:0]          exp_q[$];
  int                   rx_count;
  int                   pairs_seen;
  logic [15:0]          loop_i, loop_q;
  conv_pkg::tx_phase_e  m_state;
  logic [11:0]          hold_i, hold_q;
  logic [15:0]          src_i, src_q;
  int                   tx_pulses;
  int                   tx_fetches;
  bit                   exp_valid;
  bit                   exp_dac_valid;
  int                   target;

  conv_tb_clkgen i_clkgen (.clk_o(clk));

  conv_core uut (
    .up_clk_i       (clk),
    .reset_i        (reset_i),
    .apb_req_i      (apb_req),
    .apb_rsp_o      (apb_rsp),
    .trx_iq_i       (trx_iq),
    .trx_data_i     (trx_data),
    .tx_iq_o        (tx_iq),
    .tx_data_o      (tx_data),
    .adc_enable_i_o (adc_enable_i),
    .adc_valid_i_o  (adc_valid_i),
    .adc_data_i_o   (adc_data_i),
    .adc_enable_q_o (adc_enable_q),
    .adc_valid_q_o  (adc_valid_q),
    .adc_data_q_o   (adc_data_q),
    .adc_dovf_i     (adc_dovf),
    .dac_enable_i_o (dac_enable_i),
    .dac_valid_i_o  (dac_valid_i),
    .dac_data_i_i   (dac_data_i),
    .dac_enable_q_o (dac_enable_q),
    .dac_valid_q_o  (dac_valid_q),
    .dac_data_q_i   (dac_data_q),
    .dac_dunf_i     (dac_dunf)
  );

  // ****************************
  // helpers
  // ****************************

  // 32 bits from the upper halves of two LCG steps
  function automatic logic [31:0] next_random();
    logic [15:0] hi;
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    hi = lcg_state[31:16];
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {hi, lcg_state[31:16]};
  endfunction

  function automatic logic [15:0] expect_word(input logic [11:0] s, input logic ob);
    logic [11:0] v;
    v = s;
    if (ob) begin
      v[11] = ~v[11];
    end
    return {{4{v[11]}}, v};
  endfunction

  function automatic logic [11:0] expect_sample(input logic [15:0] w, input logic ob);
    logic [11:0] v;
    v = w[15:4];
    if (ob) begin
      v[11] = ~v[11];
    end
    return v;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want) begin
      errors++;
      $display("ERROR time=%0t %s: got 0x%0h, expected 0x%0h", $time, name, got, want);
      $display("** FAIL **");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // move to the next drive point and refresh the DMA words on a fetch
  task automatic step();
    logic [31:0] r;
    @(posedge clk);
    #2;
    if (dac_valid_i) begin
      r = next_random();
      dac_data_i = r[31:16];
      dac_data_q = r[15:0];
    end
  endtask

  // drive one bus sample and advance the pairing model
  task automatic drive_sample(input logic iq, input logic [11:0] data);
    trx_iq   = iq;
    trx_data = data;
    if (iq) begin
      pend   = 1'b1;
      held_i = data;
    end else begin
      if (pend) begin
        pairs_seen++;
        loop_i = expect_word(held_i, model_ctrl.offset_bin);
        loop_q = expect_word(data, model_ctrl.offset_bin);
        if (model_ctrl.rx_en) begin
          // Q cycle is cyc + 1 at the monitor and the pulse comes two cycles later
          exp_cyc.push_back(cyc + 3);
          exp_i.push_back(loop_i);
          exp_q.push_back(loop_q);
          rx_count++;
        end
      end
      pend = 1'b0;
    end
  endtask

  task automatic rx_stream(input int n_pairs);
    int          start;
    logic [31:0] r;
    start = pairs_seen;
    while (pairs_seen - start < n_pairs) begin
      r = next_random();
      if (r[2:0] == 3'd0) begin
        drive_sample(1'b0, r[14:3]);
        step();
      end else if (r[2:0] == 3'd1) begin
        drive_sample(1'b1, r[14:3]);
        step();
      end else begin
        drive_sample(1'b1, r[14:3]);
        step();
        drive_sample(1'b0, r[26:15]);
        step();
      end
    end
    drive_sample(1'b0, 12'h000);
    while (exp_cyc.size() > 0) begin
      step();
    end
    repeat (3) step();
  endtask

  task automatic apb_xfer(input bit wr, input logic [7:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rd, output logic slverr);
    apb_req.paddr   = addr;
    apb_req.pwrite  = wr;
    apb_req.pwdata  = wdata;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    step();
    apb_req.penable = 1'b1;
    @(negedge clk);
    rd     = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    check_value("pready", apb_rsp.pready, 1);
    step();
    apb_req = '0;
    if (wr && addr == conv_pkg::REG_CTRL) begin
      model_ctrl = wdata[3:0];
    end
    if (wr && addr == conv_pkg::REG_RX_COUNT) begin
      rx_count = 0;
    end
  endtask

  task automatic reg_write(input logic [7:0] addr, input logic [31:0] data, input bit exp_err);
    logic [31:0] rd;
    logic        slverr;
    apb_xfer(1'b1, addr, data, rd, slverr);
    check_value("pslverr", slverr, exp_err);
  endtask

  task automatic reg_read_check(input string name, input logic [7:0] addr,
                                input logic [31:0] want, input bit exp_err);
    logic [31:0] rd;
    logic        slverr;
    apb_xfer(1'b0, addr, 32'h0, rd, slverr);
    check_value("pslverr", slverr, exp_err);
    check_value(name, rd, want);
  endtask

  // ****************************
  // transmit model and monitor
  // ****************************

  always @(posedge clk) begin
    if (reset_i) begin
      m_state = conv_pkg::TX_IDLE;
      hold_i  = '0;
      hold_q  = '0;
    end else begin
      if (m_state == conv_pkg::TX_Q) begin
        if (model_ctrl.loopback) begin
          src_i = loop_i;
          src_q = loop_q;
        end else begin
          src_i = dac_data_i;
          src_q = dac_data_q;
          tx_pulses++;
        end
        hold_i = expect_sample(src_i, model_ctrl.offset_bin);
        hold_q = expect_sample(src_q, model_ctrl.offset_bin);
        tx_fetches++;
      end
      if (!model_ctrl.tx_en) begin
        m_state = conv_pkg::TX_IDLE;
      end else if (m_state == conv_pkg::TX_Q) begin
        m_state = conv_pkg::TX_I;
      end else begin
        m_state = conv_pkg::TX_Q;
      end
    end
  end

  always @(negedge clk) begin
    cyc = cyc + 1;
    if (checking) begin
      exp_valid = (exp_cyc.size() > 0) && (exp_cyc[0] == cyc);
      check_value("adc_valid_i_o", adc_valid_i, exp_valid);
      check_value("adc_valid_q_o", adc_valid_q, exp_valid);
      if (exp_valid) begin
        check_value("adc_data_i_o", adc_data_i, exp_i.pop_front());
        check_value("adc_data_q_o", adc_data_q, exp_q.pop_front());
        void'(exp_cyc.pop_front());
      end
      check_value("adc_enable_i_o", adc_enable_i, model_ctrl.rx_en);
      check_value("adc_enable_q_o", adc_enable_q, model_ctrl.rx_en);
      check_value("dac_enable_i_o", dac_enable_i, model_ctrl.tx_en);
      check_value("dac_enable_q_o", dac_enable_q, model_ctrl.tx_en);
      exp_dac_valid = (m_state == conv_pkg::TX_Q) && !model_ctrl.loopback;
      check_value("dac_valid_i_o", dac_valid_i, exp_dac_valid);
      check_value("dac_valid_q_o", dac_valid_q, exp_dac_valid);
      case (m_state)
        conv_pkg::TX_I: begin
          check_value("tx_iq_o", tx_iq, 1);
          check_value("tx_data_o", tx_data, hold_i);
        end
        conv_pkg::TX_Q: begin
          check_value("tx_iq_o", tx_iq, 0);
          check_value("tx_data_o", tx_data, hold_q);
        end
        default: begin
          check_value("tx_iq_o", tx_iq, 0);
          check_value("tx_data_o", tx_data, 0);
        end
      endcase
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired, the test sequence did not complete in time");
    $display("** FAIL **");
    $fatal(1, "timeout");
  end

  // ****************************
  // test sequence
  // ****************************

  initial begin
    lcg_state  = 32'd63;
    reset_i    = 1'b1;
    apb_req    = '0;
    trx_iq     = 1'b0;
    trx_data   = '0;
    adc_dovf   = 1'b0;
    dac_dunf   = 1'b0;
    dac_data_i = '0;
    dac_data_q = '0;
    model_ctrl = '0;
    cyc        = 0;
    errors     = 0;
    checking   = 1'b0;
    pend       = 1'b0;
    held_i     = '0;
    rx_count   = 0;
    pairs_seen = 0;
    loop_i     = '0;
    loop_q     = '0;
    tx_pulses  = 0;
    tx_fetches = 0;
    repeat (3) @(posedge clk);
    #2;
    reset_i  = 1'b0;
    checking = 1'b1;

    // APB access
    reg_read_check("version", conv_pkg::REG_VERSION, conv_pkg::CORE_VERSION, 1'b0);
    reg_write(conv_pkg::REG_CTRL, 32'h5, 1'b0);
    reg_read_check("ctrl", conv_pkg::REG_CTRL, 32'h5, 1'b0);
    reg_write(conv_pkg::REG_CTRL, 32'hFFFF_FFF0, 1'b0);
    reg_read_check("ctrl", conv_pkg::REG_CTRL, 32'h0, 1'b0);
    reg_read_check("unmapped read", 8'h10, 32'h0, 1'b1);
    reg_write(8'h14, 32'hF, 1'b1);
    reg_read_check("ctrl", conv_pkg::REG_CTRL, 32'h0, 1'b0);

    // receive conversion in two's complement and then offset binary
    reg_write(conv_pkg::REG_CTRL, 32'h1, 1'b0);
    reg_write(conv_pkg::REG_RX_COUNT, 32'h0, 1'b0);
    rx_stream(RX_PAIRS);
    reg_write(conv_pkg::REG_CTRL, 32'h5, 1'b0);
    rx_stream(RX_PAIRS);
    reg_read_check("rx_count", conv_pkg::REG_RX_COUNT, rx_count, 1'b0);

    // receive gating where the counter holds and then clears
    reg_write(conv_pkg::REG_CTRL, 32'h0, 1'b0);
    rx_stream(RX_PAIRS);
    reg_read_check("rx_count", conv_pkg::REG_RX_COUNT, rx_count, 1'b0);
    reg_write(conv_pkg::REG_RX_COUNT, 32'h0, 1'b0);
    reg_read_check("rx_count", conv_pkg::REG_RX_COUNT, 32'h0, 1'b0);

    // transmit serialization in plain and then offset binary
    reg_write(conv_pkg::REG_CTRL, 32'h2, 1'b0);
    target = tx_pulses + TX_PAIRS;
    while (tx_pulses < target) step();
    reg_write(conv_pkg::REG_CTRL, 32'h6, 1'b0);
    target = tx_pulses + TX_PAIRS;
    while (tx_pulses < target) step();
    reg_write(conv_pkg::REG_CTRL, 32'h0, 1'b0);
    repeat (3) step();

    // loopback of the last received pair
    reg_write(conv_pkg::REG_CTRL, 32'hE, 1'b0);
    tx_fetches = 0;
    while (tx_fetches < LOOP_FETCHES) step();
    reg_write(conv_pkg::REG_CTRL, 32'h0, 1'b0);
    repeat (3) step();

    // sticky flags
    adc_dovf = 1'b1;
    step();
    adc_dovf = 1'b0;
    reg_read_check("status", conv_pkg::REG_STATUS, 32'h1, 1'b0);
    reg_read_check("status", conv_pkg::REG_STATUS, 32'h1, 1'b0);
    dac_dunf = 1'b1;
    step();
    dac_dunf = 1'b0;
    reg_read_check("status", conv_pkg::REG_STATUS, 32'h3, 1'b0);
    reg_write(conv_pkg::REG_STATUS, 32'h1, 1'b0);
    reg_read_check("status", conv_pkg::REG_STATUS, 32'h2, 1'b0);
    reg_write(conv_pkg::REG_STATUS, 32'h2, 1'b0);
    reg_read_check("status", conv_pkg::REG_STATUS, 32'h0, 1'b0);

    repeat (4) step();
    if (errors == 0) begin
      $display("** PASS **");
      $finish;
    end else begin
      $display("** FAIL **");
      $fatal(1, "checks failed");
    end
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
verilog/conv_pkg.sv
verilog/conv_apb_regs.sv
verilog/conv_rx_deinterleave.sv
verilog/conv_rx_format.sv
verilog/conv_tx_interleave.sv
verilog/conv_core.sv
verification/conv_tb_clkgen.sv
verification/conv_tb.sv

// ==== Bender.yml ====
package:
  name: conv_core

sources:
  - verilog/conv_pkg.sv
  - verilog/conv_apb_regs.sv
  - verilog/conv_rx_deinterleave.sv
  - verilog/conv_rx_format.sv
  - verilog/conv_tx_interleave.sv
  - verilog/conv_core.sv
  - target: test
    files:
      - verification/conv_tb_clkgen.sv
      - verification/conv_tb.sv
